//--- mem_pkg.sv
package mem_pkg;

  localparam int WIDTH      = 32;
  localparam int NUM_ADDR   = 48;
  localparam int NUM_BANK   = 3;
  localparam int SRAM_DELAY = 2;

  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK;
  localparam int ROW_BITS  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;
  localparam int ADDR_BITS = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1;
  localparam int BANK_BITS = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1;

  typedef struct packed {
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
    logic [WIDTH-1:0]     mask;  // one bit per data bit
    logic [WIDTH-1:0]     data;
  } wr_req_t;

  typedef struct packed {
    logic                 read;
    logic [ADDR_BITS-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic                write;
    logic [ROW_BITS-1:0] wr_row;
    logic [WIDTH-1:0]    mask;
    logic [WIDTH-1:0]    din;
    logic                read;
    logic [ROW_BITS-1:0] rd_row;
  } bank_cmd_t;

  typedef struct packed {
    logic                 valid;
    logic [WIDTH-1:0]     data;
    logic                 fwrd;  // parked bits merged in
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
  } rd_rsp_t;

  typedef enum logic {PARK_EMPTY, PARK_FULL} park_state_e;

endpackage

//--- addr_split.sv
`timescale 1ns/1ps

// consecutive words land in consecutive banks, any bank count works
module addr_split #(
  parameter int NUM_ADDR = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK = mem_pkg::NUM_BANK,
  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK,
  localparam int ROW_BITS  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1,
  localparam int ADDR_BITS = (NUM_ADDR > 1) ? $clog2(NUM_ADDR) : 1,
  localparam int BANK_BITS = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
  input  logic [ADDR_BITS-1:0] addr,
  output logic [BANK_BITS-1:0] bank,
  output logic [ROW_BITS-1:0]  row
);

  logic [31:0] addr_ext;
  logic [31:0] bank_full;
  logic [31:0] row_full;

  always_comb begin
    addr_ext  = 32'(addr);
    bank_full = addr_ext % NUM_BANK;
    row_full  = addr_ext / NUM_BANK;
    bank      = bank_full[BANK_BITS-1:0];
    row       = row_full[ROW_BITS-1:0];
  end

endmodule

//--- write_defer.sv
`timescale 1ns/1ps

module write_defer import mem_pkg::*; #(
  parameter int WIDTH    = mem_pkg::WIDTH,
  parameter int NUM_ADDR = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK = mem_pkg::NUM_BANK,
  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK,
  localparam int ROW_BITS  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1,
  localparam int BANK_BITS = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_valid,
  input  logic [BANK_BITS-1:0] wr_bank,
  input  logic [ROW_BITS-1:0]  wr_row,
  input  logic [WIDTH-1:0]     wr_mask,
  input  logic [WIDTH-1:0]     wr_data,
  input  logic                 rd_valid,
  input  logic [BANK_BITS-1:0] rd_bank,
  input  logic [ROW_BITS-1:0]  rd_row,
  output logic [NUM_BANK-1:0]  bank_write,
  output logic [ROW_BITS-1:0]  bank_wr_row [NUM_BANK],
  output logic [WIDTH-1:0]     bank_mask [NUM_BANK],
  output logic [WIDTH-1:0]     bank_din [NUM_BANK],
  output logic                 fwd_hit,
  output logic [WIDTH-1:0]     fwd_mask,
  output logic [WIDTH-1:0]     fwd_data
);

  park_state_e          park_state;
  logic [BANK_BITS-1:0] park_bank;
  logic [ROW_BITS-1:0]  park_row;
  logic [WIDTH-1:0]     park_mask;
  logic [WIDTH-1:0]     park_data;

  logic                 park_full;
  logic                 collide;
  logic                 wr_hit_park;
  logic                 evict;
  logic                 sel_write;
  logic [BANK_BITS-1:0] sel_bank;
  logic [ROW_BITS-1:0]  sel_row;
  logic [WIDTH-1:0]     sel_mask;
  logic [WIDTH-1:0]     sel_data;

  always_comb begin
    park_full   = (park_state == PARK_FULL);
    collide     = wr_valid && rd_valid && (wr_bank == rd_bank) && (wr_row == rd_row);
    wr_hit_park = park_full && (wr_bank == park_bank) && (wr_row == park_row);
    evict       = collide && park_full && !wr_hit_park;  // old entry goes out this cycle
    sel_write   = evict || (wr_valid && !collide);
    sel_bank    = evict ? park_bank : wr_bank;
    sel_row     = evict ? park_row : wr_row;
    sel_mask    = evict ? park_mask : wr_mask;
    sel_data    = evict ? park_data : wr_data;
    fwd_hit     = rd_valid && park_full && (rd_bank == park_bank) && (rd_row == park_row);
    fwd_mask    = park_mask;
    fwd_data    = park_data;
  end

  always_comb begin
    for (int b = 0; b < NUM_BANK; b++) begin
      bank_write[b]  = sel_write && (sel_bank == BANK_BITS'(b));
      bank_wr_row[b] = sel_row;
      bank_mask[b]   = sel_mask;
      bank_din[b]    = sel_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      park_state <= PARK_EMPTY;
    end else if (collide) begin
      park_state <= PARK_FULL;
    end
  end

  always_ff @(posedge clk) begin
    if (collide && !wr_hit_park) begin  // empty or evicting, start over
      park_bank <= wr_bank;
      park_row  <= wr_row;
      park_mask <= wr_mask;
      park_data <= wr_data;
    end else if (wr_valid && wr_hit_park) begin
      park_mask <= park_mask | wr_mask;
      park_data <= (park_data & ~wr_mask) | (wr_data & wr_mask);
    end
  end

endmodule

//--- read_pipe.sv
`timescale 1ns/1ps

module read_pipe import mem_pkg::*; #(
  parameter int WIDTH      = mem_pkg::WIDTH,
  parameter int NUM_ADDR   = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK   = mem_pkg::NUM_BANK,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY,
  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK,
  localparam int ROW_BITS  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1,
  localparam int BANK_BITS = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_valid,
  input  logic [BANK_BITS-1:0] rd_bank,
  input  logic [ROW_BITS-1:0]  rd_row,
  input  logic                 fwd_hit,
  input  logic [WIDTH-1:0]     fwd_mask,
  input  logic [WIDTH-1:0]     fwd_data,
  output logic [NUM_BANK-1:0]  bank_read,
  output logic [ROW_BITS-1:0]  bank_rd_row [NUM_BANK],
  input  logic [WIDTH-1:0]     bank_dout [NUM_BANK],
  output rd_rsp_t              rd_rsp
);

  typedef struct packed {
    logic                 valid;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    logic                 fwd;
    logic [WIDTH-1:0]     mask;
    logic [WIDTH-1:0]     data;
  } rd_tag_t;

  rd_tag_t          tag_q [SRAM_DELAY];
  rd_tag_t          tag_in;
  rd_tag_t          tag_out;
  logic [WIDTH-1:0] bank_word;

  always_comb begin
    for (int b = 0; b < NUM_BANK; b++) begin
      bank_read[b]   = rd_valid && (rd_bank == BANK_BITS'(b));
      bank_rd_row[b] = rd_row;
    end
  end

  assign tag_in = '{valid: rd_valid, bank: rd_bank, row: rd_row, fwd: fwd_hit,
                    mask: fwd_mask, data: fwd_data};

  // one stage per cycle of bank latency, lines up with bank_dout
  always_ff @(posedge clk) begin
    tag_q[0] <= tag_in;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
    if (rst) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        tag_q[i].valid <= 1'b0;
      end
    end
  end

  always_comb begin
    tag_out      = tag_q[SRAM_DELAY-1];
    bank_word    = bank_dout[tag_out.bank];
    rd_rsp.valid = tag_out.valid;
    rd_rsp.fwrd  = tag_out.valid && tag_out.fwd;
    rd_rsp.data  = rd_rsp.fwrd ? ((tag_out.data & tag_out.mask) | (bank_word & ~tag_out.mask))
                               : bank_word;
    rd_rsp.bank  = tag_out.bank;
    rd_rsp.row   = tag_out.row;
  end

endmodule

//--- mem_1r1w.sv
`timescale 1ns/1ps

module mem_1r1w import mem_pkg::*; #(
  parameter int WIDTH      = mem_pkg::WIDTH,
  parameter int NUM_ADDR   = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK   = mem_pkg::NUM_BANK,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY,
  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK,
  localparam int ROW_BITS  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1,
  localparam int BANK_BITS = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
  input  logic       clk,
  input  logic       rst,
  input  wr_req_t    wr_req,
  input  rd_req_t    rd_req,
  output bank_cmd_t  bank_cmd [NUM_BANK],
  input  logic [WIDTH-1:0] bank_dout [NUM_BANK],
  output rd_rsp_t    rd_rsp
);

  logic [BANK_BITS-1:0] wr_bank;
  logic [ROW_BITS-1:0]  wr_row;
  logic [BANK_BITS-1:0] rd_bank;
  logic [ROW_BITS-1:0]  rd_row;

  logic [NUM_BANK-1:0]  bank_write;
  logic [ROW_BITS-1:0]  bank_wr_row [NUM_BANK];
  logic [WIDTH-1:0]     bank_mask [NUM_BANK];
  logic [WIDTH-1:0]     bank_din [NUM_BANK];
  logic [NUM_BANK-1:0]  bank_read;
  logic [ROW_BITS-1:0]  bank_rd_row [NUM_BANK];

  logic                 fwd_hit;
  logic [WIDTH-1:0]     fwd_mask;
  logic [WIDTH-1:0]     fwd_data;

  addr_split #(.NUM_ADDR(NUM_ADDR), .NUM_BANK(NUM_BANK)) u_wr_split (
    .addr(wr_req.addr), .bank(wr_bank), .row(wr_row));

  addr_split #(.NUM_ADDR(NUM_ADDR), .NUM_BANK(NUM_BANK)) u_rd_split (
    .addr(rd_req.addr), .bank(rd_bank), .row(rd_row));

  write_defer #(.WIDTH(WIDTH), .NUM_ADDR(NUM_ADDR), .NUM_BANK(NUM_BANK)) u_defer (
    .clk, .rst,
    .wr_valid(wr_req.write), .wr_bank, .wr_row, .wr_mask(wr_req.mask), .wr_data(wr_req.data),
    .rd_valid(rd_req.read), .rd_bank, .rd_row,
    .bank_write, .bank_wr_row, .bank_mask, .bank_din,
    .fwd_hit, .fwd_mask, .fwd_data);

  read_pipe #(
    .WIDTH(WIDTH), .NUM_ADDR(NUM_ADDR), .NUM_BANK(NUM_BANK), .SRAM_DELAY(SRAM_DELAY)
  ) u_pipe (
    .clk, .rst,
    .rd_valid(rd_req.read), .rd_bank, .rd_row,
    .fwd_hit, .fwd_mask, .fwd_data,
    .bank_read, .bank_rd_row, .bank_dout, .rd_rsp);

  // write half from the collision logic, read half from the pipe
  for (genvar b = 0; b < NUM_BANK; b++) begin : g_cmd
    assign bank_cmd[b] = '{write: bank_write[b], wr_row: bank_wr_row[b], mask: bank_mask[b],
                           din: bank_din[b], read: bank_read[b], rd_row: bank_rd_row[b]};
  end

endmodule

//--- bank_sram.sv
`timescale 1ns/1ps

module bank_sram import mem_pkg::*; #(
  parameter int WIDTH      = mem_pkg::WIDTH,
  parameter int NUM_ADDR   = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK   = mem_pkg::NUM_BANK,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY,
  localparam int NUM_ROW   = (NUM_ADDR + NUM_BANK - 1) / NUM_BANK
) (
  input  logic             clk,
  input  bank_cmd_t        cmd,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] mem [NUM_ROW];
  logic [WIDTH-1:0] rd_q [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.wr_row] <= (mem[cmd.wr_row] & ~cmd.mask) | (cmd.din & cmd.mask);
    end
  end

  // sampled before the write lands, so same-row read sees old data
  always_ff @(posedge clk) begin
    if (cmd.read) begin
      rd_q[0] <= mem[cmd.rd_row];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
  end

  assign dout = rd_q[SRAM_DELAY-1];

endmodule

//--- mem_1r1w_top.sv
`timescale 1ns/1ps

module mem_1r1w_top import mem_pkg::*; #(
  parameter int WIDTH      = mem_pkg::WIDTH,
  parameter int NUM_ADDR   = mem_pkg::NUM_ADDR,
  parameter int NUM_BANK   = mem_pkg::NUM_BANK,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY
) (
  input  logic    clk,
  input  logic    rst,
  input  wr_req_t wr_req,
  input  rd_req_t rd_req,
  output rd_rsp_t rd_rsp
);

  bank_cmd_t        bank_cmd [NUM_BANK];
  logic [WIDTH-1:0] bank_dout [NUM_BANK];

  mem_1r1w #(
    .WIDTH      (WIDTH),
    .NUM_ADDR   (NUM_ADDR),
    .NUM_BANK   (NUM_BANK),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_ctrl (
    .clk,
    .rst,
    .wr_req,
    .rd_req,
    .bank_cmd,
    .bank_dout,
    .rd_rsp
  );

  for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
    bank_sram #(
      .WIDTH      (WIDTH),
      .NUM_ADDR   (NUM_ADDR),
      .NUM_BANK   (NUM_BANK),
      .SRAM_DELAY (SRAM_DELAY)
    ) u_sram (
      .clk,
      .cmd  (bank_cmd[b]),
      .dout (bank_dout[b])
    );
  end

endmodule

//--- tb_mem_1r1w.sv
`timescale 1ns/1ps

module tb_mem_1r1w import mem_pkg::*; ();

  localparam int DRAIN_LIMIT = SRAM_DELAY + 20;
  localparam wr_req_t WR_IDLE = '0;
  localparam rd_req_t RD_IDLE = '0;

  logic    clk;
  logic    rst;
  wr_req_t wr_req;
  rd_req_t rd_req;
  rd_rsp_t rd_rsp;

  logic [WIDTH-1:0] shadow [NUM_ADDR];  // reference contents, request order
  logic             park_full;
  int               park_addr;
  rd_rsp_t          exp_q [$];
  int               due_q [$];
  int               cyc;
  int               errors;
  logic [31:0]      rng_state;

  mem_1r1w_top #(
    .WIDTH      (WIDTH),
    .NUM_ADDR   (NUM_ADDR),
    .NUM_BANK   (NUM_BANK),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut0 (
    .clk,
    .rst,
    .wr_req,
    .rd_req,
    .rd_rsp
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic int rand_addr();
    return int'(next_rand() % NUM_ADDR);
  endfunction

  function automatic wr_req_t wr_cmd(int addr, logic [WIDTH-1:0] mask, logic [WIDTH-1:0] data);
    return '{write: 1'b1, addr: ADDR_BITS'(addr), mask: mask, data: data};
  endfunction

  function automatic rd_req_t rd_cmd(int addr);
    return '{read: 1'b1, addr: ADDR_BITS'(addr)};
  endfunction

  task automatic check_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                            input int addr);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t: read data at addr %0d got %h expected %h", $time, addr, got, exp);
      $display("Some tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp);
    if (got.valid !== exp.valid || got.fwrd !== exp.fwrd || got.bank !== exp.bank ||
        got.row !== exp.row) begin
      errors++;
      $display("FAIL t=%0t: response fwrd/bank/row got %b/%0d/%0d expected %b/%0d/%0d",
               $time, got.fwrd, got.bank, got.row, exp.fwrd, exp.bank, exp.row);
      $display("Some tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // rd_rsp only moves at posedge, so the falling edge sees it settled
  task automatic check_outputs();
    rd_rsp_t exp;
    if (rd_rsp.valid === 1'b1) begin
      if (exp_q.size() == 0 || due_q[0] != cyc) begin
        errors++;
        $display("A read response arrived at %0t in cycle %0d when no read was due", $time, cyc);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
      end else begin
        exp = exp_q.pop_front();
        void'(due_q.pop_front());
        check_rsp(rd_rsp, exp);
        check_word(rd_rsp.data, exp.data, int'(exp.row) * NUM_BANK + int'(exp.bank));
      end
    end else if (exp_q.size() != 0 && due_q[0] == cyc) begin
      errors++;
      $display("The read response due in cycle %0d did not show up at %0t", cyc, $time);
      $display("Some tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic model_cycle(input wr_req_t w, input rd_req_t r);
    rd_rsp_t exp;
    int      wa;
    int      ra;
    wa = int'(w.addr);
    ra = int'(r.addr);
    if (r.read) begin  // taken before this cycle's write
      exp.valid = 1'b1;
      exp.data  = shadow[ra];
      exp.fwrd  = park_full && (park_addr == ra);
      exp.bank  = BANK_BITS'(ra % NUM_BANK);
      exp.row   = ROW_BITS'(ra / NUM_BANK);
      exp_q.push_back(exp);
      due_q.push_back(cyc + SRAM_DELAY);
    end
    if (w.write) begin
      shadow[wa] = (shadow[wa] & ~w.mask) | (w.data & w.mask);
      if (r.read && ra == wa) begin
        park_full = 1'b1;
        park_addr = wa;
      end
    end
  endtask

  task automatic step(input wr_req_t w, input rd_req_t r);
    check_outputs();
    wr_req = w;
    rd_req = r;
    model_cycle(w, r);
    cyc++;
    @(negedge clk);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      step(WR_IDLE, RD_IDLE);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out, %0d read responses never came", exp_q.size());
      $display("Some tests failed");
      $fatal(1, "stopping on timeout");
    end
  endtask

  initial begin
    wr_req_t w;
    rd_req_t r;
    logic [WIDTH-1:0] m;
    logic [31:0] pick;
    int a;
    rst       = 1'b1;
    wr_req    = WR_IDLE;
    rd_req    = RD_IDLE;
    park_full = 1'b0;
    park_addr = 0;
    cyc       = 0;
    errors    = 0;
    rng_state = 32'hbc969212;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (5) step(WR_IDLE, RD_IDLE);  // valid must stay low
    for (a = 0; a < NUM_ADDR; a++) begin
      step(wr_cmd(a, '1, WIDTH'(next_rand())), RD_IDLE);
    end
    step(WR_IDLE, rd_cmd(5));
    repeat (SRAM_DELAY + 3) step(WR_IDLE, RD_IDLE);

    // random masked traffic, then a sweep over every bank and row
    repeat (400) begin
      pick = next_rand();
      m = pick[1] ? WIDTH'(next_rand()) : '1;
      w = pick[0] ? wr_cmd(rand_addr(), m, WIDTH'(next_rand())) : WR_IDLE;
      r = pick[2] ? rd_cmd(rand_addr()) : RD_IDLE;
      step(w, r);
    end
    for (a = 0; a < NUM_ADDR; a++) begin
      step(WR_IDLE, rd_cmd(a));
    end
    drain();

    // same-cycle collision, then a forwarded read
    step(wr_cmd(7, WIDTH'(next_rand()), WIDTH'(next_rand())), rd_cmd(7));
    step(WR_IDLE, rd_cmd(7));
    drain();

    // alternating collisions keep evicting the parked entry
    for (int i = 0; i < 12; i++) begin
      a = (i % 2 == 0) ? 10 : 23;
      step(wr_cmd(a, WIDTH'(next_rand()), WIDTH'(next_rand())), rd_cmd(a));
    end
    step(WR_IDLE, rd_cmd(10));
    step(WR_IDLE, rd_cmd(23));
    drain();

    repeat (2000) begin
      r = rd_cmd(rand_addr());
      pick = next_rand();
      a = (pick[1:0] == 2'b00) ? int'(r.addr) : rand_addr();
      m = pick[3] ? WIDTH'(next_rand()) : '1;
      w = pick[4] ? wr_cmd(a, m, WIDTH'(next_rand())) : WR_IDLE;
      step(w, r);
    end
    drain();

    if (errors == 0 && exp_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "run ended with errors");
    end
  end

endmodule

//--- flist.f
mem_pkg.sv
addr_split.sv
write_defer.sv
read_pipe.sv
mem_1r1w.sv
bank_sram.sv
mem_1r1w_top.sv
tb_mem_1r1w.sv

//--- Bender.yml
package:
  name: mem_1r1w

sources:
  - files:
      - mem_pkg.sv
      - addr_split.sv
      - write_defer.sv
      - read_pipe.sv
      - mem_1r1w.sv
      - bank_sram.sv
      - mem_1r1w_top.sv
  - target: simulation
    files:
      - tb_mem_1r1w.sv
